// ==== regbus_pkg.sv ====
`default_nettype none

// transport types shared by the AXI-lite port and the internal register bus
package regbus_pkg;

    // AXI byte address, 2 KiB window
    localparam int ADDR_W = 11;
    // register word index is the byte address without bits 1:0
    localparam int WORD_IDX_W = ADDR_W - 2;

    typedef logic [31:0] data_t;
    typedef logic [3:0] strb_t;
    typedef logic [1:0] resp_t;

    // only OKAY is ever returned
    localparam resp_t RESP_OKAY = 2'b00;

    // request on the register bus
    // valid is a single-cycle strobe on the shared bus, held level on the slave side
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [WORD_IDX_W-1:0] word_idx;
        data_t                 wdata;
        strb_t                 wstrb;
    } regbus_req_t;

    // response from one register block
    // rdata is zero unless the block answers a read
    typedef struct packed {
        logic  ack;
        data_t rdata;
    } regbus_rsp_t;

endpackage

`default_nettype wire

// ==== rx_regs_pkg.sv ====
`default_nettype none

// register map of the receiver status and detector configuration blocks
package rx_regs_pkg;

    // word index bit that picks the block, 0 receiver and 1 detector
    localparam int BLOCK_SEL_BIT = 8;

    // word index inside one block
    typedef logic [BLOCK_SEL_BIT-1:0] reg_idx_t;

    // receiver status block
    localparam reg_idx_t REG_VERSION  = 8'd0;
    localparam reg_idx_t REG_ID       = 8'd1;
    localparam reg_idx_t REG_RESERVED = 8'd2;
    localparam reg_idx_t REG_MAGIC    = 8'd3;
    localparam reg_idx_t REG_FILL     = 8'd4;
    localparam reg_idx_t REG_FS_STATE = 8'd5;

    // detector configuration block
    localparam reg_idx_t REG_DET_THRESHOLD = 8'd0;
    localparam reg_idx_t REG_DET_CTRL      = 8'd1;
    localparam reg_idx_t REG_DET_PEAKS     = 8'd2;

    localparam regbus_pkg::data_t PCORE_VERSION = 32'h0004_0069;
    // ascii "PSSD"
    localparam regbus_pkg::data_t MAGIC_PSSD    = 32'h5053_5344;
    localparam regbus_pkg::data_t FILL_WORD     = 32'h6969_6969;

    // detector settings, control word bit 0 is enable and bits 2:1 the nid2 mode
    typedef struct packed {
        logic [31:0] threshold;
        logic        enable;
        logic [1:0]  nid2_mode;
    } det_cfg_t;

    localparam det_cfg_t DET_CFG_RESET = '{threshold: 32'h0000_0400, enable: 1'b0,
                                           nid2_mode: 2'd0};

endpackage

`default_nettype wire

// ==== axi_lite_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_lite_slave (
    input  wire logic                            clk_i,
    input  wire logic                            reset_ni,

    // write address channel
    input  wire logic [regbus_pkg::ADDR_W-1:0]   awaddr_i,
    input  wire logic                            awvalid_i,
    output logic                                 awready_o,

    // write data channel
    input  wire regbus_pkg::data_t               wdata_i,
    input  wire regbus_pkg::strb_t               wstrb_i,
    input  wire logic                            wvalid_i,
    output logic                                 wready_o,

    // write response channel
    output regbus_pkg::resp_t                    bresp_o,
    output logic                                 bvalid_o,
    input  wire logic                            bready_i,

    // read address channel
    input  wire logic [regbus_pkg::ADDR_W-1:0]   araddr_i,
    input  wire logic                            arvalid_i,
    output logic                                 arready_o,

    // read data channel
    output regbus_pkg::data_t                    rdata_o,
    output regbus_pkg::resp_t                    rresp_o,
    output logic                                 rvalid_o,
    input  wire logic                            rready_i,

    // towards the bus arbiter
    output regbus_pkg::regbus_req_t              wr_req_o,
    output regbus_pkg::regbus_req_t              rd_req_o,
    input  wire logic                            wr_ack_i,
    input  wire logic                            rd_ack_i,
    input  wire regbus_pkg::data_t               rd_data_i
);

    // per-channel FSM waits for AXI, then for the ack, then holds the response
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_BUSY,
        CH_RESP
    } ch_state_e;

    ch_state_e wr_state;
    ch_state_e rd_state;

    // latched transaction payload
    logic [regbus_pkg::WORD_IDX_W-1:0] wr_idx_q;
    logic [regbus_pkg::WORD_IDX_W-1:0] rd_idx_q;
    regbus_pkg::data_t                 wr_data_q;
    regbus_pkg::strb_t                 wr_strb_q;

    // both readies move together since address and data are taken in one cycle
    assign awready_o = (wr_state == CH_IDLE) && awvalid_i && wvalid_i;
    assign wready_o  = awready_o;
    assign arready_o = (rd_state == CH_IDLE) && arvalid_i;

    assign bvalid_o = (wr_state == CH_RESP);
    assign rvalid_o = (rd_state == CH_RESP);
    assign bresp_o  = regbus_pkg::RESP_OKAY;
    assign rresp_o  = regbus_pkg::RESP_OKAY;

    // write channel
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_state <= CH_IDLE;
        end else begin
            case (wr_state)
                CH_IDLE: if (awready_o) wr_state <= CH_BUSY;
                CH_BUSY: if (wr_ack_i) wr_state <= CH_RESP;
                CH_RESP: if (bready_i) wr_state <= CH_IDLE;
                default: wr_state <= CH_IDLE;
            endcase
        end
    end

    // byte address dropped to a word index
    always_ff @(posedge clk_i) begin
        if (awready_o) begin
            wr_idx_q  <= awaddr_i[regbus_pkg::ADDR_W-1:2];
            wr_data_q <= wdata_i;
            wr_strb_q <= wstrb_i;
        end
    end

    // read channel
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_state <= CH_IDLE;
        end else begin
            case (rd_state)
                CH_IDLE: if (arready_o) rd_state <= CH_BUSY;
                CH_BUSY: if (rd_ack_i) rd_state <= CH_RESP;
                CH_RESP: if (rready_i) rd_state <= CH_IDLE;
                default: rd_state <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (arready_o) begin
            rd_idx_q <= araddr_i[regbus_pkg::ADDR_W-1:2];
        end
        // read data arrives together with the ack and is held until rready
        if (rd_ack_i) begin
            rdata_o <= rd_data_i;
        end
    end

    // requests stay high while the channel waits for its ack
    always_comb begin
        wr_req_o.valid    = (wr_state == CH_BUSY);
        wr_req_o.we       = 1'b1;
        wr_req_o.word_idx = wr_idx_q;
        wr_req_o.wdata    = wr_data_q;
        wr_req_o.wstrb    = wr_strb_q;

        rd_req_o.valid    = (rd_state == CH_BUSY);
        rd_req_o.we       = 1'b0;
        rd_req_o.word_idx = rd_idx_q;
        rd_req_o.wdata    = '0;
        rd_req_o.wstrb    = '0;
    end

    // the arbiter acks a write only while that write is waiting
    a_wr_ack_busy : assert property (@(posedge clk_i) disable iff (!reset_ni)
        wr_ack_i |-> wr_state == CH_BUSY);
    // a read response under back-pressure is neither dropped nor changed
    a_rvalid_hold : assert property (@(posedge clk_i) disable iff (!reset_ni)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

`default_nettype wire

// ==== regbus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module regbus_arbiter (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,

    input  wire regbus_pkg::regbus_req_t wr_req_i,
    input  wire regbus_pkg::regbus_req_t rd_req_i,
    output logic                         wr_ack_o,
    output logic                         rd_ack_o,
    output regbus_pkg::data_t            rd_data_o,

    output regbus_pkg::regbus_req_t      bus_req_o,
    input  wire regbus_pkg::regbus_rsp_t rcv_rsp_i,
    input  wire regbus_pkg::regbus_rsp_t det_rsp_i
);

    // busy from grant until ack
    logic busy_q;
    // side that got the bus last
    logic last_wr_q;

    logic bus_ack;
    logic wr_pend;
    logic rd_pend;
    logic can_grant;
    logic pick_wr;
    logic pick_rd;

    // an idle block drives zero and OR merges both
    assign bus_ack   = rcv_rsp_i.ack | det_rsp_i.ack;
    assign rd_data_o = rcv_rsp_i.rdata | det_rsp_i.rdata;

    // ack goes back to the side that holds the current grant
    assign wr_ack_o = busy_q && bus_ack && last_wr_q;
    assign rd_ack_o = busy_q && bus_ack && !last_wr_q;

    // mask the side being acked since its valid is still high this cycle
    assign wr_pend = wr_req_i.valid && !wr_ack_o;
    assign rd_pend = rd_req_i.valid && !rd_ack_o;

    // a new grant may go out in the same cycle the previous ack returns
    assign can_grant = !busy_q || bus_ack;
    // on a tie the side not served last wins
    assign pick_wr   = can_grant && wr_pend && (!rd_pend || !last_wr_q);
    assign pick_rd   = can_grant && rd_pend && !pick_wr;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q          <= 1'b0;
            last_wr_q       <= 1'b0;
            bus_req_o.valid <= 1'b0;
        end else begin
            // single-cycle strobe per grant
            bus_req_o.valid <= pick_wr || pick_rd;
            if (pick_wr || pick_rd) begin
                busy_q    <= 1'b1;
                last_wr_q <= pick_wr;
                bus_req_o.we       <= pick_wr ? wr_req_i.we : rd_req_i.we;
                bus_req_o.word_idx <= pick_wr ? wr_req_i.word_idx : rd_req_i.word_idx;
                bus_req_o.wdata    <= pick_wr ? wr_req_i.wdata : rd_req_i.wdata;
                bus_req_o.wstrb    <= pick_wr ? wr_req_i.wstrb : rd_req_i.wstrb;
            end else if (bus_ack) begin
                busy_q <= 1'b0;
            end
        end
    end

    // block decode lets at most one block answer a request
    a_one_block_ack : assert property (@(posedge clk_i) disable iff (!reset_ni)
        $onehot0({rcv_rsp_i.ack, det_rsp_i.ack}));
    // every grant is acked on the next cycle
    a_ack_after_grant : assert property (@(posedge clk_i) disable iff (!reset_ni)
        bus_req_o.valid |=> bus_ack);

endmodule

`default_nettype wire

// ==== receiver_regmap.sv ====
`timescale 1ns/10ps
`default_nettype none

module receiver_regmap #(
    parameter int unsigned ID = 0
) (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,

    input  wire regbus_pkg::regbus_req_t bus_req_i,
    output regbus_pkg::regbus_rsp_t      bus_rsp_o,

    input  wire logic [1:0]              fs_state_i
);

    logic                 sel;
    rx_regs_pkg::reg_idx_t idx;
    regbus_pkg::data_t    rd_word;

    // block 0 only
    assign sel = bus_req_i.valid && !bus_req_i.word_idx[rx_regs_pkg::BLOCK_SEL_BIT];
    assign idx = bus_req_i.word_idx[rx_regs_pkg::BLOCK_SEL_BIT-1:0];

    // read mux, everything is constant except the frame-sync state
    always_comb begin
        case (idx)
            rx_regs_pkg::REG_VERSION:  rd_word = rx_regs_pkg::PCORE_VERSION;
            rx_regs_pkg::REG_ID:       rd_word = regbus_pkg::data_t'(ID);
            rx_regs_pkg::REG_RESERVED: rd_word = '0;
            rx_regs_pkg::REG_MAGIC:    rd_word = rx_regs_pkg::MAGIC_PSSD;
            rx_regs_pkg::REG_FILL:     rd_word = rx_regs_pkg::FILL_WORD;
            rx_regs_pkg::REG_FS_STATE: rd_word = regbus_pkg::data_t'(fs_state_i);
            default:                   rd_word = '0;
        endcase
    end

    // writes get their ack but touch nothing
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bus_rsp_o.ack <= 1'b0;
        end else begin
            bus_rsp_o.ack <= sel;
        end
    end

    // zero when not answering a read, the arbiter ORs both blocks
    always_ff @(posedge clk_i) begin
        bus_rsp_o.rdata <= (sel && !bus_req_i.we) ? rd_word : '0;
    end

endmodule

`default_nettype wire

// ==== detector_regmap.sv ====
`timescale 1ns/10ps
`default_nettype none

module detector_regmap (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,

    input  wire regbus_pkg::regbus_req_t bus_req_i,
    output regbus_pkg::regbus_rsp_t      bus_rsp_o,

    input  wire regbus_pkg::data_t       peak_count_i,
    output rx_regs_pkg::det_cfg_t        det_cfg_o
);

    logic                  sel;
    logic                  wr_en;
    rx_regs_pkg::reg_idx_t idx;
    regbus_pkg::data_t     rd_word;

    // block 1 only
    assign sel   = bus_req_i.valid && bus_req_i.word_idx[rx_regs_pkg::BLOCK_SEL_BIT];
    assign wr_en = sel && bus_req_i.we;
    assign idx   = bus_req_i.word_idx[rx_regs_pkg::BLOCK_SEL_BIT-1:0];

    // control word packs enable in bit 0 and mode in bits 2:1, rest reads zero
    always_comb begin
        case (idx)
            rx_regs_pkg::REG_DET_THRESHOLD: rd_word = det_cfg_o.threshold;
            rx_regs_pkg::REG_DET_CTRL:
                rd_word = {29'd0, det_cfg_o.nid2_mode, det_cfg_o.enable};
            rx_regs_pkg::REG_DET_PEAKS:     rd_word = peak_count_i;
            default:                        rd_word = '0;
        endcase
    end

    // configuration registers, each byte lane under its strobe
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_cfg_o <= rx_regs_pkg::DET_CFG_RESET;
        end else if (wr_en) begin
            if (idx == rx_regs_pkg::REG_DET_THRESHOLD) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req_i.wstrb[b]) begin
                        det_cfg_o.threshold[8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
                    end
                end
            end
            // only byte 0 of the control word carries bits
            if (idx == rx_regs_pkg::REG_DET_CTRL && bus_req_i.wstrb[0]) begin
                det_cfg_o.enable    <= bus_req_i.wdata[0];
                det_cfg_o.nid2_mode <= bus_req_i.wdata[2:1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bus_rsp_o.ack <= 1'b0;
        end else begin
            bus_rsp_o.ack <= sel;
        end
    end

    // zero unless answering a read
    always_ff @(posedge clk_i) begin
        bus_rsp_o.rdata <= (sel && !bus_req_i.we) ? rd_word : '0;
    end

endmodule

`default_nettype wire

// ==== receiver_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module receiver_ctrl_top #(
    parameter int unsigned ID = 0
) (
    input  wire logic                          clk_i,
    input  wire logic                          reset_ni,

    // AXI-lite slave port
    input  wire logic [regbus_pkg::ADDR_W-1:0] awaddr_i,
    input  wire logic                          awvalid_i,
    output logic                               awready_o,
    input  wire regbus_pkg::data_t             wdata_i,
    input  wire regbus_pkg::strb_t             wstrb_i,
    input  wire logic                          wvalid_i,
    output logic                               wready_o,
    output regbus_pkg::resp_t                  bresp_o,
    output logic                               bvalid_o,
    input  wire logic                          bready_i,
    input  wire logic [regbus_pkg::ADDR_W-1:0] araddr_i,
    input  wire logic                          arvalid_i,
    output logic                               arready_o,
    output regbus_pkg::data_t                  rdata_o,
    output regbus_pkg::resp_t                  rresp_o,
    output logic                               rvalid_o,
    input  wire logic                          rready_i,

    // datapath side
    input  wire logic [1:0]                    fs_state_i,
    input  wire regbus_pkg::data_t             peak_count_i,
    output rx_regs_pkg::det_cfg_t              det_cfg_o
);

    regbus_pkg::regbus_req_t wr_req;
    regbus_pkg::regbus_req_t rd_req;
    regbus_pkg::regbus_req_t bus_req;
    regbus_pkg::regbus_rsp_t rcv_rsp;
    regbus_pkg::regbus_rsp_t det_rsp;
    logic                    wr_ack;
    logic                    rd_ack;
    regbus_pkg::data_t       rd_data;

    axi_lite_slave u_axi (
        .clk_i, .reset_ni,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .wr_req_o (wr_req),
        .rd_req_o (rd_req),
        .wr_ack_i (wr_ack),
        .rd_ack_i (rd_ack),
        .rd_data_i(rd_data)
    );

    // write and read paths share one register bus
    regbus_arbiter u_arb (
        .clk_i, .reset_ni,
        .wr_req_i (wr_req),
        .rd_req_i (rd_req),
        .wr_ack_o (wr_ack),
        .rd_ack_o (rd_ack),
        .rd_data_o(rd_data),
        .bus_req_o(bus_req),
        .rcv_rsp_i(rcv_rsp),
        .det_rsp_i(det_rsp)
    );

    receiver_regmap #(.ID(ID)) u_rcv (
        .clk_i, .reset_ni,
        .bus_req_i (bus_req),
        .bus_rsp_o (rcv_rsp),
        .fs_state_i
    );

    detector_regmap u_det (
        .clk_i, .reset_ni,
        .bus_req_i (bus_req),
        .bus_rsp_o (det_rsp),
        .peak_count_i,
        .det_cfg_o
    );

endmodule

`default_nettype wire

// ==== tb_receiver_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_receiver_ctrl;

    typedef logic [regbus_pkg::ADDR_W-1:0] addr_t;
    typedef enum logic [1:0] {OP_WR, OP_RD, OP_WRRD} op_e;

    // one table row, waddr and raddr used as the op needs them
    typedef struct {
        string             name;
        op_e               op;
        addr_t             waddr;
        addr_t             raddr;
        regbus_pkg::data_t wdata;
        regbus_pkg::strb_t wstrb;
        regbus_pkg::data_t exp;
    } row_t;

    localparam int    HS_LIMIT = 32;
    localparam addr_t FS_ADDR  = 11'h014;
    localparam regbus_pkg::resp_t OKAY = 2'b00;
    localparam regbus_pkg::data_t PEAKS = 32'hc0de_1234;
    // threshold 0x400, detector off, mode 0
    localparam rx_regs_pkg::det_cfg_t CFG_AT_RESET = '{threshold: 32'h0000_0400,
                                                       enable: 1'b0, nid2_mode: 2'd0};

    logic                  clk_i;
    logic                  reset_ni;
    addr_t                 awaddr_i;
    logic                  awvalid_i;
    logic                  awready_o;
    regbus_pkg::data_t     wdata_i;
    regbus_pkg::strb_t     wstrb_i;
    logic                  wvalid_i;
    logic                  wready_o;
    regbus_pkg::resp_t     bresp_o;
    logic                  bvalid_o;
    logic                  bready_i;
    addr_t                 araddr_i;
    logic                  arvalid_i;
    logic                  arready_o;
    regbus_pkg::data_t     rdata_o;
    regbus_pkg::resp_t     rresp_o;
    logic                  rvalid_o;
    logic                  rready_i;
    logic [1:0]            fs_state_i;
    regbus_pkg::data_t     peak_count_i;
    rx_regs_pkg::det_cfg_t det_cfg_o;

    row_t                  tbl[$];
    rx_regs_pkg::det_cfg_t cfg_model;
    logic [31:0]           lfsr_q = 32'h99c1;
    int                    cycles = 0;
    int                    cycle_limit = 0;
    int                    err_data = 0;
    int                    err_resp = 0;
    int                    err_cfg = 0;
    int                    err_hs = 0;

    receiver_ctrl_top #(.ID(3)) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // watchdog over the whole run
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("run aborted after %0d cycles, a transaction never completed", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one bit per call
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    task automatic add_row(input string name, input op_e op, input addr_t waddr,
                           input addr_t raddr, input regbus_pkg::data_t wdata,
                           input regbus_pkg::strb_t wstrb, input regbus_pkg::data_t exp);
        row_t r;
        r = '{name, op, waddr, raddr, wdata, wstrb, exp};
        tbl.push_back(r);
    endtask

    // expected config after a write, detector block is byte address bit 10
    function automatic rx_regs_pkg::det_cfg_t model_write(input rx_regs_pkg::det_cfg_t cfg,
            input addr_t addr, input regbus_pkg::data_t data, input regbus_pkg::strb_t strb);
        if (addr[10] && addr[9:2] == 8'd0) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) cfg.threshold[8*b +: 8] = data[8*b +: 8];
            end
        end
        // control word keeps bits 2:0 only
        if (addr[10] && addr[9:2] == 8'd1 && strb[0]) begin
            cfg.enable    = data[0];
            cfg.nid2_mode = data[2:1];
        end
        return cfg;
    endfunction

    task automatic check_data(input string name, input regbus_pkg::data_t exp,
                              input regbus_pkg::data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s rdata expected %h actual %h", name, exp, act);
            err_data++;
        end
    endtask

    task automatic check_resp(input string name, input regbus_pkg::resp_t exp,
                              input regbus_pkg::resp_t act);
        if (act !== exp) begin
            $display("[FAIL] %s resp expected %h actual %h", name, exp, act);
            err_resp++;
        end
    endtask

    task automatic check_cfg(input string name, input rx_regs_pkg::det_cfg_t exp,
                             input rx_regs_pkg::det_cfg_t act);
        if (act !== exp) begin
            $display("[FAIL] %s det_cfg expected %h actual %h", name, exp, act);
            err_cfg++;
        end
    endtask

    // AW and W together, then B under random bready
    task automatic write_reg(input string name, input addr_t addr, input regbus_pkg::data_t data,
                             input regbus_pkg::strb_t strb, output regbus_pkg::resp_t resp);
        int   waited;
        logic done;
        resp = 2'b11;
        @(posedge clk_i);
        #1;
        awaddr_i  = addr;
        wdata_i   = data;
        wstrb_i   = strb;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            done = awready_o && wready_o;
            waited++;
        end while (!done && waited < HS_LIMIT);
        if (!done) begin
            $display("%s: write address and data were never accepted", name);
            err_hs++;
            awvalid_i = 1'b0;
            wvalid_i  = 1'b0;
            return;
        end
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            awvalid_i = 1'b0;
            wvalid_i  = 1'b0;
            bready_i  = next_bit();
            @(negedge clk_i);
            done = bvalid_o && bready_i;
            waited++;
        end while (!done && waited < HS_LIMIT);
        if (!done) begin
            $display("%s: no write response arrived", name);
            err_hs++;
        end
        resp = bresp_o;
        @(posedge clk_i);
        #1;
        bready_i = 1'b0;
    endtask

    // AR, then R under random rready
    task automatic read_reg(input string name, input addr_t addr,
                            output regbus_pkg::data_t data, output regbus_pkg::resp_t resp);
        int   waited;
        logic done;
        data = 'x;
        resp = 2'b11;
        @(posedge clk_i);
        #1;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        waited = 0;
        do begin
            @(negedge clk_i);
            done = arready_o;
            waited++;
        end while (!done && waited < HS_LIMIT);
        if (!done) begin
            $display("%s: read address was never accepted", name);
            err_hs++;
            arvalid_i = 1'b0;
            return;
        end
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            arvalid_i = 1'b0;
            rready_i  = next_bit();
            @(negedge clk_i);
            done = rvalid_o && rready_i;
            waited++;
        end while (!done && waited < HS_LIMIT);
        if (!done) begin
            $display("%s: no read data arrived", name);
            err_hs++;
        end
        data = rdata_o;
        resp = rresp_o;
        @(posedge clk_i);
        #1;
        rready_i = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        regbus_pkg::data_t rd;
        regbus_pkg::data_t exp;
        regbus_pkg::resp_t br;
        regbus_pkg::resp_t rr;
        // fresh frame-sync state for every row
        @(posedge clk_i);
        #1;
        fs_state_i[1] = next_bit();
        fs_state_i[0] = next_bit();
        exp = r.exp;
        if (r.op != OP_WR && r.raddr == FS_ADDR) exp = {30'd0, fs_state_i};
        case (r.op)
            OP_WR: write_reg(r.name, r.waddr, r.wdata, r.wstrb, br);
            OP_RD: read_reg(r.name, r.raddr, rd, rr);
            default: begin
                // both channels at once, the arbiter has to serve each
                fork
                    write_reg(r.name, r.waddr, r.wdata, r.wstrb, br);
                    read_reg(r.name, r.raddr, rd, rr);
                join
            end
        endcase
        if (r.op != OP_RD) begin
            cfg_model = model_write(cfg_model, r.waddr, r.wdata, r.wstrb);
            check_resp(r.name, OKAY, br);
            check_cfg(r.name, cfg_model, det_cfg_o);
        end
        if (r.op != OP_WR) begin
            check_data(r.name, exp, rd);
            check_resp(r.name, OKAY, rr);
        end
    endtask

    initial begin
        // receiver block at 0x000, detector block at 0x400
        add_row("rd_version", OP_RD, 11'h000, 11'h000, 32'h0, 4'h0, 32'h0004_0069);
        add_row("rd_id", OP_RD, 11'h000, 11'h004, 32'h0, 4'h0, 32'h0000_0003);
        add_row("rd_reserved", OP_RD, 11'h000, 11'h008, 32'h0, 4'h0, 32'h0);
        add_row("rd_magic", OP_RD, 11'h000, 11'h00c, 32'h0, 4'h0, 32'h5053_5344);
        add_row("rd_fill", OP_RD, 11'h000, 11'h010, 32'h0, 4'h0, 32'h6969_6969);
        add_row("rd_fs_state", OP_RD, 11'h000, 11'h014, 32'h0, 4'h0, 32'h0);
        add_row("rd_thr_reset", OP_RD, 11'h000, 11'h400, 32'h0, 4'h0, 32'h0000_0400);
        add_row("rd_ctrl_reset", OP_RD, 11'h000, 11'h404, 32'h0, 4'h0, 32'h0);
        add_row("wr_thr_full", OP_WR, 11'h400, 11'h000, 32'h1234_5678, 4'hf, 32'h0);
        add_row("rd_thr_full", OP_RD, 11'h000, 11'h400, 32'h0, 4'h0, 32'h1234_5678);
        add_row("wr_thr_part", OP_WR, 11'h400, 11'h000, 32'haabb_ccdd, 4'b0101, 32'h0);
        add_row("rd_thr_part", OP_RD, 11'h000, 11'h400, 32'h0, 4'h0, 32'h12bb_56dd);
        add_row("wr_thr_hi", OP_WR, 11'h400, 11'h000, 32'h9900_0000, 4'b1000, 32'h0);
        add_row("rd_thr_hi", OP_RD, 11'h000, 11'h400, 32'h0, 4'h0, 32'h99bb_56dd);
        add_row("wr_ctrl_ones", OP_WR, 11'h404, 11'h000, 32'hffff_ffff, 4'hf, 32'h0);
        add_row("rd_ctrl_ones", OP_RD, 11'h000, 11'h404, 32'h0, 4'h0, 32'h0000_0007);
        add_row("wr_version", OP_WR, 11'h000, 11'h000, 32'hdead_beef, 4'hf, 32'h0);
        add_row("rd_version_kept", OP_RD, 11'h000, 11'h000, 32'h0, 4'h0, 32'h0004_0069);
        add_row("wr_det_unmapped", OP_WR, 11'h40c, 11'h000, 32'h1111_1111, 4'hf, 32'h0);
        add_row("rd_det_unmapped", OP_RD, 11'h000, 11'h40c, 32'h0, 4'h0, 32'h0);
        add_row("rd_rcv_unmapped", OP_RD, 11'h000, 11'h03c, 32'h0, 4'h0, 32'h0);
        add_row("wrrd_thr_magic", OP_WRRD, 11'h400, 11'h00c, 32'h0000_0800, 4'hf, 32'h5053_5344);
        add_row("wrrd_fill_thr", OP_WRRD, 11'h010, 11'h400, 32'h0bad_f00d, 4'hf, 32'h0000_0800);
        add_row("wrrd_ctrl_fs", OP_WRRD, 11'h404, 11'h014, 32'h0000_0004, 4'h1, 32'h0);
        add_row("rd_ctrl_mode", OP_RD, 11'h000, 11'h404, 32'h0, 4'h0, 32'h0000_0004);
        add_row("rd_peaks", OP_RD, 11'h000, 11'h408, 32'h0, 4'h0, PEAKS);
        cycle_limit = 40 * tbl.size() + 16;

        reset_ni     = 1'b0;
        awaddr_i     = '0;
        awvalid_i    = 1'b0;
        wdata_i      = '0;
        wstrb_i      = '0;
        wvalid_i     = 1'b0;
        bready_i     = 1'b0;
        araddr_i     = '0;
        arvalid_i    = 1'b0;
        rready_i     = 1'b0;
        fs_state_i   = 2'd0;
        peak_count_i = PEAKS;
        cfg_model    = CFG_AT_RESET;

        repeat (16) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        @(negedge clk_i);
        check_cfg("after_reset", CFG_AT_RESET, det_cfg_o);

        foreach (tbl[i]) begin
            run_row(tbl[i]);
        end

        $display("errors: data %0d, resp %0d, cfg %0d, handshake %0d",
                 err_data, err_resp, err_cfg, err_hs);
        if (err_data + err_resp + err_cfg + err_hs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== receiver_ctrl.f ====
regbus_pkg.sv
rx_regs_pkg.sv
axi_lite_slave.sv
regbus_arbiter.sv
receiver_regmap.sv
detector_regmap.sv
receiver_ctrl_top.sv
tb_receiver_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receiver_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_receiver_ctrl -f receiver_ctrl.f -o sim_receiver_ctrl

out=$(./obj_dir/sim_receiver_ctrl || true)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
